// ==== dv/execStimulus.txt ====
// valid _ instr _ wb valid _ wb reg _ wb data _ pc after _ flags after {c,f,l,z,n}
// One line per cycle, a valid nibble of F ends the table
1_D105_1_1_0005_0001_00
1_F280_1_2_8000_0002_00
1_0252_1_2_0000_0003_18
1_61FF_1_1_0004_0004_18
1_517F_1_1_0083_0005_00
1_F47F_1_4_7F00_0006_00
1_0454_1_4_FE00_0007_08
1_0194_1_1_0283_0008_14
1_9201_1_2_FFFF_0009_15
1_F680_1_6_8000_000A_15
1_9601_1_6_7FFF_000B_09
1_1500_1_5_0000_000C_0B
1_25A0_1_5_00A0_000D_09
1_0535_1_5_0000_000E_0B
1_05F0_1_5_FFFF_000F_09
1_0516_1_5_7FFF_0010_09
1_01B1_0_0_0000_0011_0A
1_05B2_0_0_0000_0012_0C
1_B205_0_0_0000_0013_09
1_F784_1_7_8400_0014_09
1_8733_1_7_F080_0015_09
1_8714_1_7_0F08_0016_09
1_8704_1_7_F080_0017_09
1_8721_1_7_E100_0018_09
1_8742_1_7_7080_0019_09
1_8462_1_4_FF00_001A_09
1_D810_1_8_0010_001B_09
1_8448_1_4_0000_001C_09
1_08F0_1_8_FFEF_001D_09
1_F980_1_9_8000_001E_09
1_8968_1_9_FFFF_001F_09
1_DA03_1_A_0003_0020_09
1_896A_1_9_FFF8_0021_09
1_C003_0_0_0000_0022_09
1_C103_0_0_0000_0025_09
1_C203_0_0_0000_0026_09
1_C303_0_0_0000_0029_09
1_C403_0_0_0000_002C_09
1_C503_0_0_0000_002D_09
1_C603_0_0_0000_002E_09
1_C703_0_0_0000_0031_09
1_C803_0_0_0000_0034_09
1_C903_0_0_0000_0035_09
1_CA03_0_0_0000_0036_09
1_CB03_0_0_0000_0039_09
1_CC03_0_0_0000_003C_09
1_CD03_0_0_0000_003D_09
1_CE03_0_0_0000_0040_09
1_CF03_0_0_0000_0041_09
1_CEFE_0_0_0000_003F_09
0_0252_0_0_0000_003F_09
1_4EC6_0_0_0000_7FFF_09
1_4FC6_0_0_0000_8000_09
1_4B87_1_B_8001_7080_09
1_40C6_0_0_0000_7081_09
F_0000_0_0_0000_0000_00

// ==== dv/resultChecker.sv ====
/*
 * Result checker for the execute stage testbench
 * Latches each expectation on the edge that takes the instruction,
 * compares write-back, PC and flags half a cycle later, counts errors
 */
module resultChecker
(
	input  logic clk,
	input  logic rstN,
	input  logic expStrobe, // Expectation below belongs to the instruction on the bus
	input  cpuPkg::wbResult expWb,
	input  logic [cpuPkg::dataWidth-1:0] expPc,
	input  cpuPkg::psrFlags expFlags,
	input  cpuPkg::wbResult wb,
	input  logic [cpuPkg::dataWidth-1:0] pc,
	input  cpuPkg::psrFlags flags,
	output int checkCount,
	output int errorCount
);

	timeunit 1ns;
	timeprecision 1ps;

	logic pending; // A result is due after this edge
	cpuPkg::wbResult wbQ;
	logic [cpuPkg::dataWidth-1:0] pcQ;
	cpuPkg::psrFlags flagsQ;

	initial
	begin
		checkCount = 0;
		errorCount = 0;
	end

	task automatic compareField(input string name, input logic [15:0] got,
		input logic [15:0] exp);
		if (got !== exp)
		begin
			errorCount++;
			$display("ERR %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	always @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			pending <= 1'b0;
		end
		else
		begin
			pending <= expStrobe; // Outputs settle on this same edge
			wbQ <= expWb;
			pcQ <= expPc;
			flagsQ <= expFlags;
		end
	end

	// Falling edge, well away from the updates on the rising edge
	always @(negedge clk)
	begin
		if (pending)
		begin
			checkCount++;
			compareField("wb.valid", 16'(wb.valid), 16'(wbQ.valid));
			if (wbQ.valid)
			begin
				compareField("wb.regAddr", 16'(wb.regAddr), 16'(wbQ.regAddr));
				compareField("wb.data", wb.data, wbQ.data);
			end
			compareField("pc", pc, pcQ);
			compareField("flags", 16'(flags), 16'(flagsQ)); // Packed as c f l z n
		end
	end

endmodule

// ==== dv/tbExecCore.sv ====
/*
 * Testbench for the execute stage
 * Clock, reset, stimulus read from a data file,
 * cycle limit and the closing verdict
 */
module tbExecCore;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int maxLines = 128;
	localparam int resetCycles = 8;

	logic clk;
	logic rstN;
	logic instrValid;
	cpuPkg::instrWord instr;
	cpuPkg::wbResult wb;
	logic [cpuPkg::dataWidth-1:0] pc;
	cpuPkg::psrFlags flags;
	logic expStrobe;
	cpuPkg::wbResult expWb;
	logic [cpuPkg::dataWidth-1:0] expPc;
	cpuPkg::psrFlags expFlags;
	logic [67:0] stim [maxLines]; // valid, instr, wb valid, reg, data, pc, flags
	int lineCount;
	int cycleCount = 0;
	int cycleLimit = 0; // Zero until the stimulus length is known
	int checkCount;
	int errorCount;
	logic stimMissing;

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk; // 8 ns period
	end

	execCore uut
	(
		.clk(clk), .rstN(rstN), .instrValid(instrValid), .instr(instr),
		.wb(wb), .pc(pc), .flags(flags)
	);

	resultChecker uChecker
	(
		.clk(clk), .rstN(rstN), .expStrobe(expStrobe), .expWb(expWb),
		.expPc(expPc), .expFlags(expFlags), .wb(wb), .pc(pc), .flags(flags),
		.checkCount(checkCount), .errorCount(errorCount)
	);

	always @(posedge clk)
	begin
		cycleCount++;
		if (cycleLimit > 0 && cycleCount > cycleLimit)
		begin
			$display("Run stopped, still going after %0d cycles", cycleCount);
			$display("Simulation FAILED");
			$finish;
		end
	end

	initial
	begin
		rstN = 1'b0;
		instrValid = 1'b0;
		instr = '0;
		expStrobe = 1'b0;
		expWb = '0;
		expPc = '0;
		expFlags = '0;
		$readmemh("dv/execStimulus.txt", stim);
		lineCount = 0;
		while (lineCount < maxLines && stim[lineCount][67:64] != 4'hF)
		begin
			lineCount++; // Valid nibble F ends the table
		end
		stimMissing = (lineCount == 0);
		if (stimMissing)
		begin
			$display("No stimulus lines were read from the data file");
		end
		cycleLimit = lineCount + resetCycles + 20;
		repeat (resetCycles) @(posedge clk);
		#1 rstN = 1'b1;
		for (int i = 0; i < lineCount; i++)
		begin
			@(posedge clk);
			#1;
			instrValid = stim[i][64];
			instr = stim[i][63:48];
			expWb.valid = stim[i][44];
			expWb.regAddr = stim[i][43:40];
			expWb.data = stim[i][39:24];
			expPc = stim[i][23:8];
			expFlags = stim[i][4:0];
			expStrobe = 1'b1;
		end
		@(posedge clk);
		#1;
		instrValid = 1'b0;
		expStrobe = 1'b0;
		repeat (2) @(posedge clk); // Let the last comparison happen
		#1;
		if (checkCount != lineCount)
		begin
			$display("Only %0d of %0d stimulus lines were checked", checkCount, lineCount);
		end
		$display("Checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0 && !stimMissing && checkCount == lineCount)
		begin
			$display("Simulation PASSED");
		end
		else
		begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

// ==== run.sh ====
#!/bin/sh
# Build with Verilator, run, and pass only when the pass line appears
cd "$(dirname "$0")" &&
verilator --binary --timing --timescale 1ns/1ps -f sources.f --top-module tbExecCore \
	-o simExecCore &&
./obj_dir/simExecCore 2>&1 | tee /dev/stderr | grep -qx "Simulation PASSED" ||
{ echo "Run did not pass"; exit 1; }

// ==== sources.f ====
verilog/cpuPkg.sv
verilog/instrDecode.sv
verilog/regFile.sv
verilog/alu.sv
verilog/pcControl.sv
verilog/execCore.sv
dv/resultChecker.sv
dv/tbExecCore.sv

// ==== verilog/alu.sv ====
/*
 * ALU of the execute stage
 * Logic, add and subtract, compare, moves and shifts,
 * flag values with their write mask, link value and branch or jump target
 */
module alu
(
	input  cpuPkg::execCtrl ctrl,
	input  logic [cpuPkg::dataWidth-1:0] opA, // Rdest value
	input  logic [cpuPkg::dataWidth-1:0] opB, // Rsrc value or immediate
	input  logic [cpuPkg::dataWidth-1:0] pc,
	output logic [cpuPkg::dataWidth-1:0] result,
	output cpuPkg::flagUpdate flagUpd,
	output logic [cpuPkg::dataWidth-1:0] target
);

	localparam int w = cpuPkg::dataWidth;
	localparam int amtW = $clog2(w); // Bits of an in-range shift amount

	logic [w:0] sum; // Top bit is carry out
	logic [w:0] diff; // Top bit is borrow
	logic addOvf;
	logic subOvf;
	logic unsignedLess;
	logic signedLess;
	logic equal;
	logic [w-1:0] logicOut;
	logic shiftRight;
	logic shiftArith;
	logic shiftBig; // Amount of w or more
	logic [w-1:0] shiftMag; // Magnitude of the signed amount
	logic signed [w-1:0] ashrOut;
	logic [w-1:0] shiftOut;

	assign sum = {1'b0, opA} + {1'b0, opB};
	assign diff = {1'b0, opA} - {1'b0, opB};
	// Same input signs but the sum sign differs
	assign addOvf = (opA[w-1] == opB[w-1]) && (sum[w-1] != opA[w-1]);
	// Input signs differ and the difference follows the subtrahend
	assign subOvf = (opA[w-1] != opB[w-1]) && (diff[w-1] != opA[w-1]);
	assign unsignedLess = opA < opB;
	assign signedLess = $signed(opA) < $signed(opB);
	assign equal = opA == opB;

	always_comb
	begin
		case (ctrl.op)
			cpuPkg::opAnd: logicOut = opA & opB;
			cpuPkg::opOr: logicOut = opA | opB;
			cpuPkg::opXor: logicOut = opA ^ opB;
			default: logicOut = ~opA; // NOT complements Rdest
		endcase
	end

	// Immediate amounts arrive zero-extended so only register amounts go negative
	assign shiftArith = ctrl.op inside {cpuPkg::opAshR, cpuPkg::opAshReg};
	assign shiftRight = (ctrl.op inside {cpuPkg::opLshR, cpuPkg::opAshR})
		|| ((ctrl.op inside {cpuPkg::opLshReg, cpuPkg::opAshReg}) && opB[w-1]);
	assign shiftMag = opB[w-1] ? (~opB + 1'b1) : opB;
	assign shiftBig = |shiftMag[w-1:amtW];
	assign ashrOut = $signed(opA) >>> shiftMag[amtW-1:0]; // Sign fill

	always_comb
	begin
		if (shiftBig)
		begin
			shiftOut = (shiftArith && shiftRight) ? {w{opA[w-1]}} : '0; // All shifted out
		end
		else if (shiftRight)
		begin
			shiftOut = shiftArith ? ashrOut : (opA >> shiftMag[amtW-1:0]);
		end
		else
		begin
			shiftOut = opA << shiftMag[amtW-1:0]; // Left is the same for both kinds
		end
	end

	always_comb
	begin
		result = '0;
		flagUpd = '0; // No flag written by default
		target = opB; // Jcond and JAL go to Rsrc
		case (ctrl.op)
			cpuPkg::opAnd, cpuPkg::opOr, cpuPkg::opXor, cpuPkg::opNot:
			begin
				result = logicOut;
				flagUpd.value.z = (logicOut == '0);
				flagUpd.mask.z = 1'b1; // Other flags persist
			end
			cpuPkg::opAdd:
			begin
				result = sum[w-1:0];
				flagUpd.value.c = sum[w];
				flagUpd.value.f = addOvf;
				flagUpd.mask.c = 1'b1;
				flagUpd.mask.f = 1'b1;
			end
			cpuPkg::opAddu: result = sum[w-1:0]; // Flags untouched
			cpuPkg::opSub:
			begin
				result = diff[w-1:0];
				flagUpd.value = '{c: diff[w], f: subOvf, l: unsignedLess, z: equal,
					n: signedLess};
				flagUpd.mask = '1;
			end
			cpuPkg::opCmp: // Compare only, no write-back
			begin
				flagUpd.value.l = unsignedLess;
				flagUpd.value.z = equal;
				flagUpd.value.n = signedLess;
				flagUpd.mask.l = 1'b1;
				flagUpd.mask.z = 1'b1;
				flagUpd.mask.n = 1'b1;
			end
			cpuPkg::opMov, cpuPkg::opLui: result = opB; // LUI byte already placed
			cpuPkg::opLshL, cpuPkg::opLshR, cpuPkg::opAshL, cpuPkg::opAshR,
			cpuPkg::opLshReg, cpuPkg::opAshReg: result = shiftOut;
			cpuPkg::opBranch: target = pc + ctrl.imm; // Signed displacement
			cpuPkg::opJal: result = pc + 1'b1; // Link value
			default: result = '0; // JUMP and NOP produce no data
		endcase
	end

endmodule

// ==== verilog/cpuPkg.sv ====
/*
 * Shared definitions for the execute stage
 * Word width, the two views of an instruction word,
 * ALU operation and branch condition codes,
 * status flags with their write mask, decoded control and write-back record
 */
package cpuPkg;

	localparam int dataWidth = 16; // Data and instruction word size

	// One word, read as register form or immediate form
	typedef union packed {
		struct packed {
			logic [3:0] opcode;
			logic [3:0] rDest; // Condition code for Bcond and Jcond
			logic [3:0] opExt; // Secondary opcode
			logic [3:0] rSrc;
		} regForm;
		struct packed {
			logic [3:0] opcode;
			logic [3:0] rDest;
			logic [7:0] imm; // Raw 8-bit immediate or branch displacement
		} immForm;
	} instrWord;

	typedef enum logic [4:0] {
		opNop, opAnd, opOr, opXor, opNot, // Logic
		opAdd, opAddu, opSub, opCmp, // Arithmetic and compare
		opMov, opLui, // Moves
		opLshL, opLshR, opAshL, opAshR, // Shift by immediate amount
		opLshReg, opAshReg, // Shift by signed register amount
		opBranch, opJump, opJal // Control flow
	} aluOpE;

	typedef enum logic [3:0] {
		condEq = 4'h0, condNe = 4'h1, condCs = 4'h2, condCc = 4'h3,
		condHi = 4'h4, condLs = 4'h5, condGt = 4'h6, condLe = 4'h7,
		condFs = 4'h8, condFc = 4'h9, condLo = 4'hA, condHs = 4'hB,
		condLt = 4'hC, condGe = 4'hD, condUc = 4'hE, condNj = 4'hF
	} condE;

	typedef struct packed {
		logic c; // Carry or borrow
		logic f; // Signed overflow
		logic l; // Unsigned lower
		logic z; // Zero or equal
		logic n; // Signed lower
	} psrFlags;

	typedef struct packed {
		psrFlags value; // New flag values
		psrFlags mask; // Set bit means write that flag
	} flagUpdate;

	typedef struct packed {
		aluOpE op;
		logic [3:0] rDest;
		logic [3:0] rSrc;
		logic useImm; // Second operand from imm instead of Rsrc
		logic [dataWidth-1:0] imm; // Already extended or shifted
		logic regWrite; // Result goes to Rdest
		condE cond;
	} execCtrl;

	typedef struct packed {
		logic valid;
		logic [3:0] regAddr; // Register that was written
		logic [dataWidth-1:0] data;
	} wbResult;

endpackage

// ==== verilog/execCore.sv ====
/*
 * Execute stage top level
 * Decoder, register file, ALU and PC control,
 * second operand select and registered write-back record
 */
module execCore
(
	input  logic clk,
	input  logic rstN,
	input  logic instrValid,
	input  cpuPkg::instrWord instr,
	output cpuPkg::wbResult wb,
	output logic [cpuPkg::dataWidth-1:0] pc,
	output cpuPkg::psrFlags flags
);

	cpuPkg::execCtrl ctrl;
	cpuPkg::flagUpdate flagUpd;
	logic [cpuPkg::dataWidth-1:0] rdData1;
	logic [cpuPkg::dataWidth-1:0] rdData2;
	logic [cpuPkg::dataWidth-1:0] opB;
	logic [cpuPkg::dataWidth-1:0] aluResult;
	logic [cpuPkg::dataWidth-1:0] target;
	logic regWe;

	instrDecode uDecode (.instr(instr), .ctrl(ctrl));

	assign regWe = instrValid && ctrl.regWrite; // No write on idle cycles
	assign opB = ctrl.useImm ? ctrl.imm : rdData2; // Immediate or Rsrc

	regFile uRegFile
	(
		.clk(clk), .rstN(rstN),
		.rdAddr1(ctrl.rDest), .rdAddr2(ctrl.rSrc),
		.rdData1(rdData1), .rdData2(rdData2),
		.wrEn(regWe), .wrAddr(ctrl.rDest), .wrData(aluResult)
	);

	alu uAlu
	(
		.ctrl(ctrl), .opA(rdData1), .opB(opB), .pc(pc),
		.result(aluResult), .flagUpd(flagUpd), .target(target)
	);

	pcControl uPcControl
	(
		.clk(clk), .rstN(rstN), .instrValid(instrValid),
		.op(ctrl.op), .cond(ctrl.cond), .flagUpd(flagUpd), .target(target),
		.pc(pc), .flags(flags)
	);

	// Write-back record mirrors the register write one cycle later
	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			wb <= '0;
		end
		else
		begin
			wb.valid <= regWe; // High for exactly one cycle per write
			wb.regAddr <= ctrl.rDest;
			wb.data <= aluResult;
		end
	end

endmodule

// ==== verilog/instrDecode.sv ====
/*
 * Instruction decoder
 * Maps opcode and opExt to an ALU operation,
 * extends the immediate and picks write and branch controls
 */
module instrDecode
(
	input  cpuPkg::instrWord instr,
	output cpuPkg::execCtrl ctrl
);

	localparam int w = cpuPkg::dataWidth;

	logic [w-1:0] immSext; // Sign-extended 8-bit field
	logic [w-1:0] immZext; // Zero-extended 8-bit field
	logic [w-1:0] shiftAmt; // 4-bit amount from the Rsrc slot

	assign immSext = {{(w-8){instr.immForm.imm[7]}}, instr.immForm.imm};
	assign immZext = {{(w-8){1'b0}}, instr.immForm.imm};
	assign shiftAmt = {{(w-4){1'b0}}, instr.regForm.rSrc};

	always_comb
	begin
		ctrl.op = cpuPkg::opNop; // Unknown words fall through as NOP
		ctrl.rDest = instr.regForm.rDest;
		ctrl.rSrc = instr.regForm.rSrc;
		ctrl.useImm = 1'b0;
		ctrl.imm = '0;
		ctrl.cond = cpuPkg::condUc;
		case (instr.regForm.opcode)
			4'h0: // Register-register group
			begin
				case (instr.regForm.opExt)
					4'h1: ctrl.op = cpuPkg::opAnd;
					4'h2: ctrl.op = cpuPkg::opOr;
					4'h3: ctrl.op = cpuPkg::opXor;
					4'h5: ctrl.op = cpuPkg::opAdd;
					4'h6: ctrl.op = cpuPkg::opAddu;
					4'h9: ctrl.op = cpuPkg::opSub;
					4'hB: ctrl.op = cpuPkg::opCmp;
					4'hD: ctrl.op = cpuPkg::opMov;
					4'hF: ctrl.op = cpuPkg::opNot;
					default: ctrl.op = cpuPkg::opNop;
				endcase
			end
			4'h1: {ctrl.op, ctrl.useImm, ctrl.imm} = {cpuPkg::opAnd, 1'b1, immZext}; // ANDI
			4'h2: {ctrl.op, ctrl.useImm, ctrl.imm} = {cpuPkg::opOr, 1'b1, immZext}; // ORI
			4'h3: {ctrl.op, ctrl.useImm, ctrl.imm} = {cpuPkg::opXor, 1'b1, immZext}; // XORI
			4'h5: {ctrl.op, ctrl.useImm, ctrl.imm} = {cpuPkg::opAdd, 1'b1, immSext}; // ADDI
			4'h6: {ctrl.op, ctrl.useImm, ctrl.imm} = {cpuPkg::opAddu, 1'b1, immSext}; // ADDUI
			4'h9: {ctrl.op, ctrl.useImm, ctrl.imm} = {cpuPkg::opSub, 1'b1, immSext}; // SUBI
			4'hB: {ctrl.op, ctrl.useImm, ctrl.imm} = {cpuPkg::opCmp, 1'b1, immSext}; // CMPI
			4'hD: {ctrl.op, ctrl.useImm, ctrl.imm} = {cpuPkg::opMov, 1'b1, immZext}; // MOVI
			4'hF: // LUI puts the byte on top
			begin
				ctrl.op = cpuPkg::opLui;
				ctrl.useImm = 1'b1;
				ctrl.imm = {instr.immForm.imm, {(w-8){1'b0}}};
			end
			4'h8: // Shift group, opExt bit 0 is the immediate direction
			begin
				ctrl.imm = shiftAmt;
				case (instr.regForm.opExt[3:1])
					3'b000: {ctrl.op, ctrl.useImm} = instr.regForm.opExt[0] ?
						{cpuPkg::opLshR, 1'b1} : {cpuPkg::opLshL, 1'b1}; // LSHI
					3'b001: {ctrl.op, ctrl.useImm} = instr.regForm.opExt[0] ?
						{cpuPkg::opAshR, 1'b1} : {cpuPkg::opAshL, 1'b1}; // ASHUI
					3'b010: ctrl.op = instr.regForm.opExt[0] ? cpuPkg::opNop : cpuPkg::opLshReg;
					3'b011: ctrl.op = instr.regForm.opExt[0] ? cpuPkg::opNop : cpuPkg::opAshReg;
					default: ctrl.op = cpuPkg::opNop;
				endcase
			end
			4'hC: // Bcond, displacement is signed
			begin
				ctrl.op = cpuPkg::opBranch;
				ctrl.useImm = 1'b1;
				ctrl.imm = immSext;
				ctrl.cond = cpuPkg::condE'(instr.immForm.rDest);
			end
			4'h4: // LOAD and STOR stay NOP, no memory here
			begin
				case (instr.regForm.opExt)
					4'h8: ctrl.op = cpuPkg::opJal;
					4'hC:
					begin
						ctrl.op = cpuPkg::opJump; // Jcond
						ctrl.cond = cpuPkg::condE'(instr.regForm.rDest);
					end
					default: ctrl.op = cpuPkg::opNop;
				endcase
			end
			default: ctrl.op = cpuPkg::opNop;
		endcase
		// Compare, NOP and plain branches leave the register file alone
		ctrl.regWrite = !(ctrl.op inside {cpuPkg::opNop, cpuPkg::opCmp,
			cpuPkg::opBranch, cpuPkg::opJump});
	end

endmodule

// ==== verilog/pcControl.sv ====
/*
 * Status register and program counter
 * Condition check on the stored flags, next PC choice,
 * masked flag writes on valid cycles
 */
module pcControl
(
	input  logic clk,
	input  logic rstN,
	input  logic instrValid,
	input  cpuPkg::aluOpE op,
	input  cpuPkg::condE cond,
	input  cpuPkg::flagUpdate flagUpd,
	input  logic [cpuPkg::dataWidth-1:0] target,
	output logic [cpuPkg::dataWidth-1:0] pc,
	output cpuPkg::psrFlags flags
);

	logic taken;
	logic doJump;
	logic [cpuPkg::dataWidth-1:0] pcNext;
	cpuPkg::psrFlags flagsNext;

	always_comb
	begin
		case (cond)
			cpuPkg::condEq: taken = flags.z;
			cpuPkg::condNe: taken = !flags.z;
			cpuPkg::condCs: taken = flags.c;
			cpuPkg::condCc: taken = !flags.c;
			cpuPkg::condHi: taken = !flags.l && !flags.z; // Unsigned above
			cpuPkg::condLs: taken = flags.l || flags.z;
			cpuPkg::condGt: taken = !flags.n && !flags.z; // Signed above
			cpuPkg::condLe: taken = flags.n || flags.z;
			cpuPkg::condFs: taken = flags.f;
			cpuPkg::condFc: taken = !flags.f;
			cpuPkg::condLo: taken = flags.l;
			cpuPkg::condHs: taken = !flags.l;
			cpuPkg::condLt: taken = flags.n;
			cpuPkg::condGe: taken = !flags.n;
			cpuPkg::condUc: taken = 1'b1;
			default: taken = 1'b0; // NJ never taken
		endcase
	end

	// JAL always jumps, branches and jumps only when the condition holds
	assign doJump = (op == cpuPkg::opJal)
		|| ((op == cpuPkg::opBranch || op == cpuPkg::opJump) && taken);
	assign pcNext = doJump ? target : pc + 1'b1;
	assign flagsNext = (flags & ~flagUpd.mask) | (flagUpd.value & flagUpd.mask);

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			pc <= '0;
			flags <= '0;
		end
		else if (instrValid) // Idle cycles hold state
		begin
			pc <= pcNext;
			flags <= flagsNext; // Only masked bits change
		end
	end

endmodule

// ==== verilog/regFile.sv ====
/*
 * Register file
 * Sixteen words, two combinational read ports, one clocked write port
 */
module regFile
(
	input  logic clk,
	input  logic rstN,
	input  logic [3:0] rdAddr1,
	input  logic [3:0] rdAddr2,
	output logic [cpuPkg::dataWidth-1:0] rdData1,
	output logic [cpuPkg::dataWidth-1:0] rdData2,
	input  logic wrEn,
	input  logic [3:0] wrAddr,
	input  logic [cpuPkg::dataWidth-1:0] wrData
);

	logic [cpuPkg::dataWidth-1:0] regs [16]; // R0 to R15

	// Reads see the stored value, a write this cycle lands on the edge
	assign rdData1 = regs[rdAddr1]; // Rdest operand
	assign rdData2 = regs[rdAddr2]; // Rsrc operand

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			for (int i = 0; i < 16; i++)
			begin
				regs[i] <= '0; // Whole file starts at zero
			end
		end
		else if (wrEn)
		begin
			regs[wrAddr] <= wrData;
		end
	end

endmodule
